/* rtl/ncpu_ro_pkg.sv */
package ncpu_ro_pkg;

   // Physical register address for a 64-entry file
   localparam int prf_aw = 6;
   localparam int prf_depth = 1 << prf_aw;

   // ALU opcode carried to execute
   localparam int alu_opw = 8;

   localparam int pc_w = 30;        // Word address without the byte offset

   // Reorder buffer id of the instruction
   localparam int rob_id_w = 4;

endpackage

/* rtl/prf_rd_if.sv */
`timescale 1ns/1ps

interface prf_rd_if
#(
   parameter int config_dw = 32
);

   // Source 1 read port
   logic                            re1;
   logic [ncpu_ro_pkg::prf_aw-1:0]  raddr1;
   logic [config_dw-1:0]            rdata1;

   // Source 2 read port
   logic                            re2;
   logic [ncpu_ro_pkg::prf_aw-1:0]  raddr2;
   logic [config_dw-1:0]            rdata2;

   modport stage
   (
      output re1, raddr1, re2, raddr2,
      input  rdata1, rdata2
   );

   modport rf
   (
      input  re1, raddr1, re2, raddr2,
      output rdata1, rdata2
   );

endinterface

/* rtl/hds_buf.sv */
`timescale 1ns/1ps

module hds_buf
(
   input  logic clk,
   input  logic rst_n,
   input  logic flush,
   input  logic in_valid,
   input  logic out_ready,
   output logic in_ready,
   output logic out_valid,
   output logic p_ce
);

   logic full;

   // Accept when empty, or when the held entry leaves this cycle
   assign in_ready  = ~full | out_ready;
   assign p_ce      = in_valid & in_ready;   // Load strobe for the payload
   assign out_valid = full;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         full <= 1'b0;
      end
      else if (flush)
      begin
         full <= 1'b0;                        // Drops held and incoming entry
      end
      else if (p_ce)
      begin
         full <= 1'b1;
      end
      else if (out_ready)
      begin
         full <= 1'b0;                        // Execute took it and nothing new came
      end
   end

endmodule

/* rtl/ro.sv */
`timescale 1ns/1ps

module ro
#(
   parameter int config_dw = 32,
   parameter int config_p_issue_width = 1,
   localparam int iw = 1 << config_p_issue_width
)
(
   input  logic                                     clk,
   input  logic                                     rst_n,
   input  logic                                     flush,
   // Issue side
   input  logic [iw-1:0]                            ro_valid,
   output logic [iw-1:0]                            ro_ready,
   input  logic [iw*ncpu_ro_pkg::alu_opw-1:0]       ro_alu_opc,
   input  logic [iw*config_dw-1:0]                  ro_imm,
   input  logic [iw*ncpu_ro_pkg::pc_w-1:0]          ro_pc,
   input  logic [iw*ncpu_ro_pkg::prf_aw-1:0]        ro_prd,
   input  logic [iw-1:0]                            ro_prd_we,
   input  logic [iw*ncpu_ro_pkg::prf_aw-1:0]        ro_prs1,
   input  logic [iw-1:0]                            ro_prs1_re,
   input  logic [iw*ncpu_ro_pkg::prf_aw-1:0]        ro_prs2,
   input  logic [iw-1:0]                            ro_prs2_re,
   input  logic [iw*ncpu_ro_pkg::rob_id_w-1:0]      ro_rob_id,
   // Register file read ports, one pair per lane
   prf_rd_if.stage                                  rd_ports [iw],
   // Execute side
   output logic [iw-1:0]                            ex_valid,
   input  logic [iw-1:0]                            ex_ready,
   output logic [iw*ncpu_ro_pkg::alu_opw-1:0]       ex_alu_opc,
   output logic [iw*config_dw-1:0]                  ex_imm,
   output logic [iw*ncpu_ro_pkg::pc_w-1:0]          ex_pc,
   output logic [iw*ncpu_ro_pkg::prf_aw-1:0]        ex_prd,
   output logic [iw-1:0]                            ex_prd_we,
   output logic [iw*config_dw-1:0]                  ex_operand1,
   output logic [iw*config_dw-1:0]                  ex_operand2,
   output logic [iw*ncpu_ro_pkg::rob_id_w-1:0]      ex_rob_id
);

   localparam int opw = ncpu_ro_pkg::alu_opw;
   localparam int pcw = ncpu_ro_pkg::pc_w;
   localparam int aw  = ncpu_ro_pkg::prf_aw;
   localparam int rw  = ncpu_ro_pkg::rob_id_w;

   for (genvar i = 0; i < iw; i++)
   begin : g_lane
      logic                 p_ce;
      logic [opw-1:0]       alu_opc_q;
      logic [config_dw-1:0] imm_q;
      logic [pcw-1:0]       pc_q;
      logic [aw-1:0]        prd_q;
      logic                 prd_we_q;
      logic [rw-1:0]        rob_id_q;
      logic                 prs1_re_q;          // Operand 1 from register
      logic                 prs2_re_q;          // Operand 2 from register

      // Each lane handshakes on its own
      hds_buf u_buf
      (
         .clk       (clk),
         .rst_n     (rst_n),
         .flush     (flush),
         .in_valid  (ro_valid[i]),
         .out_ready (ex_ready[i]),
         .in_ready  (ro_ready[i]),
         .out_valid (ex_valid[i]),
         .p_ce      (p_ce)
      );

      always_ff @(posedge clk)
      begin
         if (p_ce)
         begin
            alu_opc_q <= ro_alu_opc[i*opw +: opw];
            imm_q     <= ro_imm[i*config_dw +: config_dw];
            pc_q      <= ro_pc[i*pcw +: pcw];
            prd_q     <= ro_prd[i*aw +: aw];
            prd_we_q  <= ro_prd_we[i];
            rob_id_q  <= ro_rob_id[i*rw +: rw];
            prs1_re_q <= ro_prs1_re[i];
            prs2_re_q <= ro_prs2_re[i];
         end
      end

      // Register file reads on the same edge as the payload load
      assign rd_ports[i].re1    = p_ce & ro_prs1_re[i];
      assign rd_ports[i].raddr1 = ro_prs1[i*aw +: aw];
      assign rd_ports[i].re2    = p_ce & ro_prs2_re[i];
      assign rd_ports[i].raddr2 = ro_prs2[i*aw +: aw];

      assign ex_alu_opc[i*opw +: opw]          = alu_opc_q;
      assign ex_imm[i*config_dw +: config_dw]  = imm_q;
      assign ex_pc[i*pcw +: pcw]               = pc_q;
      assign ex_prd[i*aw +: aw]                = prd_q;
      assign ex_prd_we[i]                      = prd_we_q;
      assign ex_rob_id[i*rw +: rw]             = rob_id_q;

      // Register data or immediate
      assign ex_operand1[i*config_dw +: config_dw] = prs1_re_q ? rd_ports[i].rdata1 : imm_q;
      assign ex_operand2[i*config_dw +: config_dw] = prs2_re_q ? rd_ports[i].rdata2 : imm_q;
   end

endmodule

/* rtl/prf.sv */
`timescale 1ns/1ps

module prf
#(
   parameter int config_dw = 32,
   parameter int config_p_issue_width = 1,
   localparam int iw = 1 << config_p_issue_width
)
(
   input  logic                             clk,
   // Writeback port
   input  logic                             wb_we,
   input  logic [ncpu_ro_pkg::prf_aw-1:0]   wb_addr,
   input  logic [config_dw-1:0]             wb_data,
   // Read ports, two per lane
   prf_rd_if.rf                             rd_ports [iw]
);

   logic [config_dw-1:0] regs [ncpu_ro_pkg::prf_depth];

   // Write-first view of one entry
   function automatic logic [config_dw-1:0] rd_word
   (
      input logic [ncpu_ro_pkg::prf_aw-1:0] addr
   );
      if (wb_we && (wb_addr == addr))
      begin
         return wb_data;
      end
      return regs[addr];
   endfunction

   always_ff @(posedge clk)
   begin
      if (wb_we)
      begin
         regs[wb_addr] <= wb_data;
      end
   end

   for (genvar i = 0; i < iw; i++)
   begin : g_rd
      // Data holds until the next enabled read
      always_ff @(posedge clk)
      begin
         if (rd_ports[i].re1)
         begin
            rd_ports[i].rdata1 <= rd_word(rd_ports[i].raddr1);
         end
         if (rd_ports[i].re2)
         begin
            rd_ports[i].rdata2 <= rd_word(rd_ports[i].raddr2);
         end
      end
   end

endmodule

/* rtl/ro_top.sv */
`timescale 1ns/1ps

module ro_top
#(
   parameter int config_dw = 32,
   parameter int config_p_issue_width = 1,
   localparam int iw = 1 << config_p_issue_width
)
(
   input  logic                                     clk,
   input  logic                                     rst_n,
   input  logic                                     flush,
   // Writeback
   input  logic                                     wb_we,
   input  logic [ncpu_ro_pkg::prf_aw-1:0]           wb_addr,
   input  logic [config_dw-1:0]                     wb_data,
   // Issue lanes
   input  logic [iw-1:0]                            ro_valid,
   output logic [iw-1:0]                            ro_ready,
   input  logic [iw*ncpu_ro_pkg::alu_opw-1:0]       ro_alu_opc,
   input  logic [iw*config_dw-1:0]                  ro_imm,
   input  logic [iw*ncpu_ro_pkg::pc_w-1:0]          ro_pc,
   input  logic [iw*ncpu_ro_pkg::prf_aw-1:0]        ro_prd,
   input  logic [iw-1:0]                            ro_prd_we,
   input  logic [iw*ncpu_ro_pkg::prf_aw-1:0]        ro_prs1,
   input  logic [iw-1:0]                            ro_prs1_re,
   input  logic [iw*ncpu_ro_pkg::prf_aw-1:0]        ro_prs2,
   input  logic [iw-1:0]                            ro_prs2_re,
   input  logic [iw*ncpu_ro_pkg::rob_id_w-1:0]      ro_rob_id,
   // Execute lanes
   output logic [iw-1:0]                            ex_valid,
   input  logic [iw-1:0]                            ex_ready,
   output logic [iw*ncpu_ro_pkg::alu_opw-1:0]       ex_alu_opc,
   output logic [iw*config_dw-1:0]                  ex_imm,
   output logic [iw*ncpu_ro_pkg::pc_w-1:0]          ex_pc,
   output logic [iw*ncpu_ro_pkg::prf_aw-1:0]        ex_prd,
   output logic [iw-1:0]                            ex_prd_we,
   output logic [iw*config_dw-1:0]                  ex_operand1,
   output logic [iw*config_dw-1:0]                  ex_operand2,
   output logic [iw*ncpu_ro_pkg::rob_id_w-1:0]      ex_rob_id
);

   // One read port pair per lane
   prf_rd_if #(.config_dw(config_dw)) rd_ports [iw] ();

   ro
   #(
      .config_dw            (config_dw),
      .config_p_issue_width (config_p_issue_width)
   )
   u_ro
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .ro_valid    (ro_valid),
      .ro_ready    (ro_ready),
      .ro_alu_opc  (ro_alu_opc),
      .ro_imm      (ro_imm),
      .ro_pc       (ro_pc),
      .ro_prd      (ro_prd),
      .ro_prd_we   (ro_prd_we),
      .ro_prs1     (ro_prs1),
      .ro_prs1_re  (ro_prs1_re),
      .ro_prs2     (ro_prs2),
      .ro_prs2_re  (ro_prs2_re),
      .ro_rob_id   (ro_rob_id),
      .rd_ports    (rd_ports),
      .ex_valid    (ex_valid),
      .ex_ready    (ex_ready),
      .ex_alu_opc  (ex_alu_opc),
      .ex_imm      (ex_imm),
      .ex_pc       (ex_pc),
      .ex_prd      (ex_prd),
      .ex_prd_we   (ex_prd_we),
      .ex_operand1 (ex_operand1),
      .ex_operand2 (ex_operand2),
      .ex_rob_id   (ex_rob_id)
   );

   prf
   #(
      .config_dw            (config_dw),
      .config_p_issue_width (config_p_issue_width)
   )
   u_prf
   (
      .clk      (clk),
      .wb_we    (wb_we),
      .wb_addr  (wb_addr),
      .wb_data  (wb_data),
      .rd_ports (rd_ports)
   );

endmodule

/* verification/ro_top_tb.sv */
`timescale 1ns/1ps

module ro_top_tb;

   localparam int dw  = 32;
   localparam int iw  = 2;
   localparam int opw = ncpu_ro_pkg::alu_opw;
   localparam int pcw = ncpu_ro_pkg::pc_w;
   localparam int aw  = ncpu_ro_pkg::prf_aw;
   localparam int rw  = ncpu_ro_pkg::rob_id_w;
   localparam int wait_limit = 20;      // Cycles before a wait gives up

   typedef struct packed
   {
      logic [opw-1:0] opc;
      logic [dw-1:0]  imm;
      logic [pcw-1:0] pc;
      logic [aw-1:0]  prd;
      logic           prd_we;
      logic [aw-1:0]  prs1;
      logic           prs1_re;
      logic [aw-1:0]  prs2;
      logic           prs2_re;
      logic [rw-1:0]  rob;
   } instr_t;

   logic clk, rst_n, flush, wb_we;
   logic [aw-1:0]      wb_addr;
   logic [dw-1:0]      wb_data;
   logic [iw-1:0]      ro_valid, ro_ready, ro_prd_we, ro_prs1_re, ro_prs2_re;
   logic [iw*opw-1:0]  ro_alu_opc, ex_alu_opc;
   logic [iw*dw-1:0]   ro_imm, ex_imm, ex_operand1, ex_operand2;
   logic [iw*pcw-1:0]  ro_pc, ex_pc;
   logic [iw*aw-1:0]   ro_prd, ro_prs1, ro_prs2, ex_prd;
   logic [iw*rw-1:0]   ro_rob_id, ex_rob_id;
   logic [iw-1:0]      ex_valid, ex_ready, ex_prd_we;

   logic [dw-1:0] rf_model [1 << aw];   // Expected register contents
   logic [31:0]   lcg_state = 32'h25cc_c358;
   int            errors = 0;
   int            checks = 0;

   ro_top UUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic instr_t build_instr(input logic [opw-1:0] opc, input logic [dw-1:0] imm,
      input logic [pcw-1:0] pc, input logic [aw-1:0] prd, input logic prd_we,
      input logic [aw-1:0] prs1, input logic prs1_re, input logic [aw-1:0] prs2,
      input logic prs2_re, input logic [rw-1:0] rob);
      return '{opc, imm, pc, prd, prd_we, prs1, prs1_re, prs2, prs2_re, rob};
   endfunction

   // Register value when read, else the immediate
   function automatic logic [dw-1:0] expected_operand(input logic re, input logic [aw-1:0] addr,
      input logic [dw-1:0] imm);
      return re ? rf_model[addr] : imm;
   endfunction

   task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
      checks++;
      if (expected !== actual)
      begin
         errors++;
         $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic write_reg(input logic [aw-1:0] addr, input logic [dw-1:0] data);
      wb_we   = 1'b1;
      wb_addr = addr;
      wb_data = data;
      @(negedge clk);
      wb_we = 1'b0;
      rf_model[addr] = data;
   endtask

   task automatic drive_instr(input int lane, input instr_t in);
      ro_alu_opc[lane*opw +: opw] = in.opc;
      ro_imm[lane*dw +: dw]       = in.imm;
      ro_pc[lane*pcw +: pcw]      = in.pc;
      ro_prd[lane*aw +: aw]       = in.prd;
      ro_prd_we[lane]             = in.prd_we;
      ro_prs1[lane*aw +: aw]      = in.prs1;
      ro_prs1_re[lane]            = in.prs1_re;
      ro_prs2[lane*aw +: aw]      = in.prs2;
      ro_prs2_re[lane]            = in.prs2_re;
      ro_rob_id[lane*rw +: rw]    = in.rob;
      ro_valid[lane]              = 1'b1;
   endtask

   // Hold valid until every lane in mask is ready, then pass one edge
   task automatic accept(input logic [iw-1:0] mask, input string name);
      int n;
      n = 0;
      while (((ro_ready & mask) != mask) && (n < wait_limit))
      begin
         @(negedge clk);
         n++;
      end
      if ((ro_ready & mask) != mask)
      begin
         errors++;
         $display("%s: issue side was never ready", name);
      end
      @(negedge clk);
      ro_valid = ro_valid & ~mask;
   endtask

   task automatic wait_ex(input int lane, input string name);
      int lat;
      lat = 1;                          // Acceptance edge already passed
      while (!ex_valid[lane] && (lat <= wait_limit))
      begin
         @(negedge clk);
         lat++;
      end
      if (!ex_valid[lane])
      begin
         errors++;
         $display("%s: ex_valid on lane %0d never rose", name, lane);
      end
      check({name, " latency"}, 1, lat);
   endtask

   task automatic check_ex(input string name, input int lane, input instr_t in,
      input logic [dw-1:0] op1, input logic [dw-1:0] op2);
      check({name, " ex_valid"}, 1, ex_valid[lane]);
      check({name, " alu_opc"}, in.opc, ex_alu_opc[lane*opw +: opw]);
      check({name, " imm"}, in.imm, ex_imm[lane*dw +: dw]);
      check({name, " pc"}, in.pc, ex_pc[lane*pcw +: pcw]);
      check({name, " prd"}, in.prd, ex_prd[lane*aw +: aw]);
      check({name, " prd_we"}, in.prd_we, ex_prd_we[lane]);
      check({name, " rob_id"}, in.rob, ex_rob_id[lane*rw +: rw]);
      check({name, " operand1"}, op1, ex_operand1[lane*dw +: dw]);
      check({name, " operand2"}, op2, ex_operand2[lane*dw +: dw]);
   endtask

   // Sends one instruction on lane 0 and checks what reaches execute
   task automatic run_lane0(input string name, input instr_t in);
      logic [dw-1:0] op1, op2;
      op1 = expected_operand(in.prs1_re, in.prs1, in.imm);
      op2 = expected_operand(in.prs2_re, in.prs2, in.imm);
      drive_instr(0, in);
      accept(2'b01, name);
      wait_ex(0, name);
      check_ex(name, 0, in, op1, op2);
   endtask

   task automatic end_test(input string name, input int start_errors);
      $display("test %s finished with %0d errors", name, errors - start_errors);
   endtask

   task automatic reset_and_read();
      int e0;
      e0 = errors;
      check("reset ex_valid", 0, ex_valid);
      check("reset ro_ready", 2'b11, ro_ready);
      ex_ready = '1;
      write_reg(6'd5, 32'h1111_2222);
      write_reg(6'd9, 32'h3333_4444);
      run_lane0("read both", build_instr(8'h3c, 32'h55, 30'h1000, 6'd12, 1, 6'd5, 1, 6'd9, 1, 4'd7));
      @(negedge clk);
      check("read both drained", 0, ex_valid[0]);
      end_test("reset_and_read", e0);
   endtask

   task automatic immediate_select();
      int e0;
      e0 = errors;
      write_reg(6'd3, 32'hcafe_0003);
      write_reg(6'd4, 32'hbeef_0004);
      run_lane0("imm both", build_instr(8'h11, 32'h0a5a, 30'h2000, 6'd1, 0, 6'd3, 0, 6'd4, 0, 4'd1));
      run_lane0("imm op2", build_instr(8'h12, 32'hffff_f000, 30'h2001, 6'd2, 1, 6'd3, 1, 6'd4, 0,
         4'd2));
      @(negedge clk);
      end_test("immediate_select", e0);
   endtask

   task automatic back_pressure();
      instr_t        first, second;
      logic [dw-1:0] f1, f2;
      int            e0;
      e0 = errors;
      ex_ready[0] = 1'b0;
      write_reg(6'd10, 32'h0a0a_0a0a);
      write_reg(6'd11, 32'h0b0b_0b0b);
      first = build_instr(8'h21, 32'h100, 30'h3000, 6'd20, 1, 6'd10, 1, 6'd11, 1, 4'd3);
      f1 = rf_model[10];
      f2 = rf_model[11];
      run_lane0("bp first", first);
      second = build_instr(8'h22, 32'h200, 30'h3001, 6'd21, 0, 6'd10, 1, 6'd11, 0, 4'd4);
      drive_instr(0, second);
      check("bp ro_ready low", 0, ro_ready[0]);
      write_reg(6'd10, 32'h5a5a_5a5a);   // Held operands must not follow this
      @(negedge clk);
      check_ex("bp first held", 0, first, f1, f2);
      check("bp ro_ready still low", 0, ro_ready[0]);
      ex_ready[0] = 1'b1;
      @(negedge clk);                   // First leaves as the second enters
      ro_valid[0] = 1'b0;
      wait_ex(0, "bp second");
      check_ex("bp second", 0, second, 32'h5a5a_5a5a, second.imm);
      @(negedge clk);
      check("bp drained", 0, ex_valid[0]);
      end_test("back_pressure", e0);
   endtask

   task automatic write_first();
      instr_t in;
      int     e0;
      e0 = errors;
      write_reg(6'd20, 32'h1234_0000);
      in = build_instr(8'h31, 32'h0, 30'h4000, 6'd22, 1, 6'd20, 1, 6'd20, 1, 4'd5);
      wb_we   = 1'b1;                   // Same edge as the acceptance
      wb_addr = 6'd20;
      wb_data = 32'h8765_4321;
      drive_instr(0, in);
      @(negedge clk);
      wb_we       = 1'b0;
      ro_valid[0] = 1'b0;
      rf_model[20] = 32'h8765_4321;
      wait_ex(0, "write first");
      check_ex("write first", 0, in, rf_model[20], rf_model[20]);
      @(negedge clk);
      end_test("write_first", e0);
   endtask

   task automatic flush_held();
      int e0;
      e0 = errors;
      ex_ready[0] = 1'b0;
      write_reg(6'd25, 32'hdead_0025);
      run_lane0("flush held", build_instr(8'h35, 32'h7, 30'h4100, 6'd23, 1, 6'd25, 1, 6'd0, 0,
         4'd6));
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      check("flush ex_valid", 0, ex_valid[0]);
      check("flush ro_ready", 1, ro_ready[0]);
      ex_ready[0] = 1'b1;
      repeat (3)
      begin
         @(negedge clk);
         check("flush nothing to execute", 0, ex_valid[0]);
      end
      end_test("flush_held", e0);
   endtask

   task automatic dual_lane();
      instr_t        held, in;
      logic [dw-1:0] h1, h2, a1, a2;
      int            r;
      int            e0;
      e0 = errors;
      ex_ready = 2'b01;                 // Lane 1 stalled
      for (r = 30; r < 34; r++)
      begin
         write_reg(aw'(r), lcg_next());
      end
      held = build_instr(8'h41, lcg_next(), 30'h5000, 6'd40, 1, 6'd32, 1, 6'd33, 0, 4'd8);
      in   = build_instr(8'h40, lcg_next(), 30'h5100, 6'd41, 1, 6'd30, 1, 6'd31, 1, 4'd9);
      h1 = expected_operand(held.prs1_re, held.prs1, held.imm);
      h2 = expected_operand(held.prs2_re, held.prs2, held.imm);
      a1 = expected_operand(in.prs1_re, in.prs1, in.imm);
      a2 = expected_operand(in.prs2_re, in.prs2, in.imm);
      drive_instr(0, in);
      drive_instr(1, held);
      accept(2'b11, "dual");
      wait_ex(0, "dual lane0");
      wait_ex(1, "dual lane1");
      check_ex("dual lane0", 0, in, a1, a2);
      check_ex("dual lane1", 1, held, h1, h2);
      for (r = 0; r < 3; r++)
      begin
         write_reg(aw'(30 + r), lcg_next());
         run_lane0("dual lane0 stream", build_instr(opw'(8'h50 + r), lcg_next(),
            pcw'(30'h5200 + r), 6'd42, 1, aw'(30 + r), 1, 6'd31, r[0], rw'(10 + r)));
         check_ex("dual lane1 held", 1, held, h1, h2);
         check("dual lane1 ro_ready", 0, ro_ready[1]);
      end
      ex_ready[1] = 1'b1;
      @(negedge clk);
      check("dual lane1 drained", 0, ex_valid[1]);
      end_test("dual_lane", e0);
   endtask

   // Bound on the whole run
   initial
   begin
      #1_000_000;
      $display("simulation time limit reached before the tests ended");
      $display("Done: errors found");
      $finish;
   end

   initial
   begin
      rst_n = 1'b0;
      flush = 1'b0;
      wb_we = 1'b0;
      wb_addr = '0;
      wb_data = '0;
      ro_valid = '0;
      ro_alu_opc = '0;
      ro_imm = '0;
      ro_pc = '0;
      ro_prd = '0;
      ro_prd_we = '0;
      ro_prs1 = '0;
      ro_prs1_re = '0;
      ro_prs2 = '0;
      ro_prs2_re = '0;
      ro_rob_id = '0;
      ex_ready = '0;                    // Ready then shows the empty buffer alone
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      reset_and_read();
      immediate_select();
      back_pressure();
      write_first();
      flush_held();
      dual_lane();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Done: no errors");
      end
      else
      begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* ro_top.f */
rtl/ncpu_ro_pkg.sv
rtl/prf_rd_if.sv
rtl/hds_buf.sv
rtl/ro.sv
rtl/prf.sv
rtl/ro_top.sv
verification/ro_top_tb.sv
